// ==== vlog.f ====
ball_pkg.sv
player_pos_delay.sv
ball_fsm.sv
ball_motion.sv
ball_pos_ctrl.sv
tb_ball_pos_ctrl.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing
TOP = tb_ball_pos_ctrl
FILE_LIST = vlog.f
PASS_TEXT = All checks passed

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(shell cat $(FILE_LIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf obj_dir

// ==== tb_ball_pos_ctrl.sv ====
module tb_ball_pos_ctrl;
  timeunit 1ns;
  timeprecision 1ps;

  // model states
  localparam int s_hang = 0, s_bounce = 1, s_flight = 2, s_rest = 3;

  logic clk100Hz;
  logic rst_d;
  logic pl1_col, pl2_col, net_col, ovr_touch, last_touch;
  ball_pkg::pos_t pl1_pos, pl2_pos, ball_pos;
  logic gnd_col;

  int errors, checks, seed;
  string test_name;
  // reference model with position and velocity in 1/128 pixel
  int m_state, m_col, m_x, m_y, m_vx, m_vy, m_rest, m_ghost;
  logic m_ovr;
  ball_pkg::pos_t h1 [3];
  ball_pkg::pos_t h2 [3];

  ball_pos_ctrl i_dut (.*);

  initial
  begin
    clk100Hz = 1'b0;
    forever #10 clk100Hz = ~clk100Hz;
  end

  task automatic check_val(input string what, input int exp, input int act);
    checks++;
    if (exp != act)
    begin
      errors++;
      $display("mismatch %s %s expected %0d actual %0d", test_name, what, exp, act);
    end
  endtask

  // drive one tick of inputs, check the DUT and advance the model
  task automatic step(input logic p1, input logic p2, input logic net, input logic ovr);
    int nx, ny, nvx, nvy, ns;
    logic gnd, wall;
    ball_pkg::pos_t pd;
    pl1_col <= p1;
    pl2_col <= p2;
    net_col <= net;
    ovr_touch <= ovr;
    @(negedge clk100Hz);
    nx = m_x;
    ny = m_y;
    nvx = 0;
    nvy = 0;
    if (m_state == s_hang)
    begin
      nx = (last_touch ? 774 : 250) * 128;
      ny = 555 * 128;
    end
    else if (m_state == s_flight)
    begin
      nx = m_x + m_vx;
      ny = m_y - m_vy;
      nvx = m_vx;
      nvy = (m_vy <= -369) ? m_vy : m_vy - 16;
    end
    else if (m_state == s_bounce)
    begin
      pd = (m_col == 2) ? h2[2] : h1[2];
      nvx = m_vx;
      nvy = m_vy;
      // offset between centres divided by 8
      if (m_col == 1 || m_col == 2)
      begin
        nvx = ((m_x >>> 7) - int'(pd.x) + 32 - 38) * 16;
        nvy = (int'(pd.y) - (m_y >>> 7) + 70 - 32) * 16;
      end
      else if (m_col == 3)
        nvx = -m_vx;
    end
    wall = ((nx >>> 7) <= 5) || ((nx >>> 7) >= 954);
    gnd = (ny >>> 7) >= 686;
    check_val("x", (m_x >>> 7) & 12'hfff, int'(ball_pos.x));
    check_val("y", (m_y >>> 7) & 12'hfff, int'(ball_pos.y));
    check_val("gnd_col", int'(gnd), int'(gnd_col));
    ns = m_state;
    case (m_state)
      s_hang:
      begin
        m_col = p1 ? 1 : (p2 ? 2 : 0);
        if (p1 || p2)
        begin
          ns = s_bounce;
          m_ovr = ovr;
        end
      end
      s_bounce:
        ns = m_ovr ? s_rest : s_flight;
      s_flight:
        if ((p1 || p2) && m_ghost == 25)
        begin
          ns = s_bounce;
          m_col = p1 ? 1 : 2;
          m_ovr = ovr;
        end
        else if (wall || net)
        begin
          ns = s_bounce;
          m_col = 3;
          m_ovr = 1'b0;
        end
        else if (gnd)
          ns = s_rest;
      default:
        if (m_rest == 250)
          ns = s_hang;
    endcase
    m_rest = (m_state == s_rest) ? m_rest + 1 : 0;
    m_ghost = (m_state == s_flight) ? ((m_ghost == 25) ? 25 : m_ghost + 1) : 0;
    m_state = ns;
    m_x = nx;
    m_y = ny;
    m_vx = nvx;
    m_vy = nvy;
    h1[2] = h1[1];
    h1[1] = h1[0];
    h1[0] = pl1_pos;
    h2[2] = h2[1];
    h2[1] = h2[0];
    h2[0] = pl2_pos;
    @(posedge clk100Hz);
  endtask

  task automatic idle(input int n);
    repeat (n) step(1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  // move both players, then let the delay line settle
  task automatic place(input int x1, input int y1, input int x2, input int y2);
    pl1_pos.x <= x1[11:0];
    pl1_pos.y <= y1[11:0];
    pl2_pos.x <= x2[11:0];
    pl2_pos.y <= y2[11:0];
    idle(4);
  endtask

  task automatic land_and_rest();
    int n;
    n = 0;
    while (m_state != s_rest && n < 3000)
    begin
      idle(1);
      n++;
    end
    if (n >= 3000)
    begin
      errors++;
      $display("%s: timeout, the ball never reached the ground", test_name);
    end
    n = 0;
    while (m_state != s_hang && n < 300)
    begin
      idle(1);
      n++;
    end
    if (n >= 300)
    begin
      errors++;
      $display("%s: timeout, the ball never left the rest state", test_name);
    end
    idle(2);
  endtask

  task automatic serve_and_side_swap();
    test_name = "serve";
    idle(2);
    last_touch <= 1'b1;
    idle(3);
    last_touch <= 1'b0;
    idle(3);
  endtask

  task automatic launch_and_ghost();
    int off;
    test_name = "launch";
    off = $random(seed) % 17;
    place(244 + off, 600, 700, 600);
    step(1'b1, 1'b0, 1'b0, 1'b0);
    idle(20);
    test_name = "ghost";
    step(1'b1, 1'b0, 1'b0, 1'b0);
    idle(10);
    off = $random(seed) % 17;
    place((m_x >>> 7) - 10 + off, (m_y >>> 7) + 30, 700, 600);
    step(1'b1, 1'b0, 1'b0, 1'b0);
    idle(20);
    test_name = "ground";
    land_and_rest();
  endtask

  task automatic wall_and_net();
    test_name = "wall";
    place(450, 600, 700, 600);
    step(1'b1, 1'b0, 1'b0, 1'b0);
    idle(16);
    test_name = "net";
    step(1'b0, 1'b0, 1'b1, 1'b0);
    idle(5);
    land_and_rest();
  endtask

  task automatic overtouch_rest();
    test_name = "overtouch";
    last_touch <= 1'b1;
    idle(3);
    step(1'b0, 1'b1, 1'b0, 1'b1);
    // serve side changes during rest but the ball stays frozen
    last_touch <= 1'b0;
    idle(255);
  endtask

  initial
  begin
    seed = 32'hdd1f6afd;
    errors = 0;
    checks = 0;
    rst_d <= 1'b1;
    pl1_col <= 1'b0;
    pl2_col <= 1'b0;
    net_col <= 1'b0;
    ovr_touch <= 1'b0;
    last_touch <= 1'b0;
    pl1_pos <= '0;
    pl2_pos <= '0;
    repeat (16) @(posedge clk100Hz);
    rst_d <= 1'b0;
    m_state = s_hang;
    m_col = 0;
    m_ovr = 1'b0;
    m_x = 250 * 128;
    m_y = 555 * 128;
    m_vx = 0;
    m_vy = 0;
    m_rest = 0;
    m_ghost = 0;
    for (int i = 0; i < 3; i++)
    begin
      h1[i] = '0;
      h2[i] = '0;
    end
    serve_and_side_swap();
    launch_and_ghost();
    wall_and_net();
    overtouch_rest();
    $display("errors: %0d of %0d checks", errors, checks);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// ==== ball_pos_ctrl.sv ====
module ball_pos_ctrl (
  input  logic           clk100Hz,
  input  logic           rst_d,
  input  logic           pl1_col,
  input  logic           pl2_col,
  input  logic           net_col,
  input  logic           ovr_touch,
  input  logic           last_touch,
  input  ball_pkg::pos_t pl1_pos,
  input  ball_pkg::pos_t pl2_pos,
  output ball_pkg::pos_t ball_pos,
  output logic           gnd_col
);

  ball_pkg::pos_t        pl1_pos_d;
  ball_pkg::pos_t        pl2_pos_d;
  ball_pkg::ball_state_e state;
  ball_pkg::collision_e  last_col;
  logic                  wall_col;

  player_pos_delay i_pos_delay (
    .clk100Hz  (clk100Hz),
    .rst_d     (rst_d),
    .pl1_pos   (pl1_pos),
    .pl2_pos   (pl2_pos),
    .pl1_pos_d (pl1_pos_d),
    .pl2_pos_d (pl2_pos_d)
  );

  ball_fsm i_fsm (
    .clk100Hz  (clk100Hz),
    .rst_d     (rst_d),
    .pl1_col   (pl1_col),
    .pl2_col   (pl2_col),
    .net_col   (net_col),
    .ovr_touch (ovr_touch),
    .wall_col  (wall_col),
    .gnd_col   (gnd_col),
    .state     (state),
    .last_col  (last_col)
  );

  ball_motion i_motion (
    .clk100Hz   (clk100Hz),
    .rst_d      (rst_d),
    .last_touch (last_touch),
    .state      (state),
    .last_col   (last_col),
    .pl1_pos_d  (pl1_pos_d),
    .pl2_pos_d  (pl2_pos_d),
    .ball_pos   (ball_pos),
    .wall_col   (wall_col),
    .gnd_col    (gnd_col)
  );

endmodule

// ==== ball_motion.sv ====
module ball_motion (
  input  logic                  clk100Hz,
  input  logic                  rst_d,
  input  logic                  last_touch,
  input  ball_pkg::ball_state_e state,
  input  ball_pkg::collision_e  last_col,
  input  ball_pkg::pos_t        pl1_pos_d,
  input  ball_pkg::pos_t        pl2_pos_d,
  output ball_pkg::pos_t        ball_pos,
  output logic                  wall_col,
  output logic                  gnd_col
);

  ball_pkg::fix_t pos_x;
  ball_pkg::fix_t pos_y;
  ball_pkg::fix_t pos_x_nxt;
  ball_pkg::fix_t pos_y_nxt;
  ball_pkg::fix_t vel_x;
  ball_pkg::fix_t vel_y;
  ball_pkg::fix_t vel_x_nxt;
  ball_pkg::fix_t vel_y_nxt;
  ball_pkg::pos_t pl_pos;
  ball_pkg::pix_t dx;
  ball_pkg::pix_t dy;
  logic [12:0]    nx_int;
  logic [12:0]    ny_int;

  function automatic ball_pkg::fix_t to_fix(input ball_pkg::coord_t c);
    return ball_pkg::fix_t'({1'b0, c, 7'b0000000});
  endfunction

  always_ff @(posedge clk100Hz)
  begin
    if (rst_d)
    begin
      pos_x <= to_fix(ball_pkg::start_x_pl1);
      pos_y <= to_fix(ball_pkg::start_y);
      vel_x <= '0;
      vel_y <= '0;
    end
    else
    begin
      pos_x <= pos_x_nxt;
      pos_y <= pos_y_nxt;
      vel_x <= vel_x_nxt;
      vel_y <= vel_y_nxt;
    end
  end

  always_comb
  begin
    pos_x_nxt = pos_x;
    pos_y_nxt = pos_y;
    case (state)
      ball_pkg::hang:
      begin
        pos_x_nxt = (last_touch == ball_pkg::player1) ? to_fix(ball_pkg::start_x_pl1) :
                                                        to_fix(ball_pkg::start_x_pl2);
        pos_y_nxt = to_fix(ball_pkg::start_y);
      end
      // screen y grows downwards, vel_y is positive upwards
      ball_pkg::flight:
      begin
        pos_x_nxt = pos_x + vel_x;
        pos_y_nxt = pos_y - vel_y;
      end
      default:
      begin
        pos_x_nxt = pos_x;
        pos_y_nxt = pos_y;
      end
    endcase
  end

  assign pl_pos = (last_col == ball_pkg::col_pl2) ? pl2_pos_d : pl1_pos_d;

  // offsets between sprite centres, integer pixels
  assign dx = pos_x[19:7] - {1'b0, pl_pos.x} + {1'b0, ball_pkg::ball_center}
              - {1'b0, ball_pkg::pl_center_x};
  assign dy = {1'b0, pl_pos.y} - pos_y[19:7] + {1'b0, ball_pkg::pl_center_y}
              - {1'b0, ball_pkg::ball_center};

  always_comb
  begin
    vel_x_nxt = '0;
    vel_y_nxt = '0;
    case (state)
      ball_pkg::bounce:
      begin
        vel_x_nxt = vel_x;
        vel_y_nxt = vel_y;
        if (last_col == ball_pkg::col_pl1 || last_col == ball_pkg::col_pl2)
        begin
          // offset / 8 pixel per tick
          vel_x_nxt = {{3{dx[12]}}, dx, 4'b0000};
          vel_y_nxt = {{3{dy[12]}}, dy, 4'b0000};
        end
        else if (last_col == ball_pkg::col_wall)
          vel_x_nxt = -vel_x;
      end
      ball_pkg::flight:
      begin
        vel_x_nxt = vel_x;
        vel_y_nxt = (vel_y <= ball_pkg::vel_y_min) ? vel_y : vel_y - ball_pkg::gravity;
      end
      default:
      begin
        vel_x_nxt = '0;
        vel_y_nxt = '0;
      end
    endcase
  end

  assign nx_int = pos_x_nxt[19:7];
  assign ny_int = pos_y_nxt[19:7];

  // negative x wraps high, so it counts as a right wall hit too
  assign wall_col = (nx_int <= {1'b0, ball_pkg::wall_left}) ||
                    (nx_int >= {1'b0, ball_pkg::wall_right - ball_pkg::ball_size});
  assign gnd_col = !ny_int[12] &&
                   (ny_int >= {1'b0, ball_pkg::gnd_lvl - ball_pkg::ball_size});

  assign ball_pos.x = pos_x[18:7];
  assign ball_pos.y = pos_y[18:7];

endmodule

// ==== ball_fsm.sv ====
module ball_fsm (
  input  logic                 clk100Hz,
  input  logic                 rst_d,
  input  logic                 pl1_col,
  input  logic                 pl2_col,
  input  logic                 net_col,
  input  logic                 ovr_touch,
  input  logic                 wall_col,
  input  logic                 gnd_col,
  output ball_pkg::ball_state_e state,
  output ball_pkg::collision_e  last_col
);

  ball_pkg::ball_state_e state_nxt;
  ball_pkg::collision_e  last_col_nxt;
  ball_pkg::rest_cnt_t   rest_cnt;
  ball_pkg::ghost_cnt_t  ghost_cnt;
  logic                  ovr_q;
  logic                  ovr_nxt;
  logic                  pl_col;
  logic                  ghost_done;
  logic                  rest_done;

  assign pl_col = pl1_col | pl2_col;
  assign ghost_done = (ghost_cnt == ball_pkg::ghost_ticks);
  assign rest_done = (rest_cnt == ball_pkg::rest_ticks);

  always_ff @(posedge clk100Hz)
  begin
    if (rst_d)
    begin
      state <= ball_pkg::hang;
      last_col <= ball_pkg::col_none;
      ovr_q <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      last_col <= last_col_nxt;
      ovr_q <= ovr_nxt;
    end
  end

  always_comb
  begin
    state_nxt = state;
    last_col_nxt = last_col;
    ovr_nxt = ovr_q;
    case (state)
      ball_pkg::hang:
      begin
        last_col_nxt = pl1_col ? ball_pkg::col_pl1 :
                       pl2_col ? ball_pkg::col_pl2 : ball_pkg::col_none;
        if (pl_col)
        begin
          state_nxt = ball_pkg::bounce;
          ovr_nxt = ovr_touch;
        end
      end
      // one tick, velocity gets loaded here
      ball_pkg::bounce:
        state_nxt = ovr_q ? ball_pkg::rest : ball_pkg::flight;
      ball_pkg::flight:
      begin
        if (pl_col && ghost_done)
        begin
          state_nxt = ball_pkg::bounce;
          last_col_nxt = pl1_col ? ball_pkg::col_pl1 : ball_pkg::col_pl2;
          ovr_nxt = ovr_touch;
        end
        else if (wall_col || net_col)
        begin
          state_nxt = ball_pkg::bounce;
          last_col_nxt = ball_pkg::col_wall;
          ovr_nxt = 1'b0;
        end
        else if (gnd_col)
          state_nxt = ball_pkg::rest;
      end
      ball_pkg::rest:
        if (rest_done)
          state_nxt = ball_pkg::hang;
      default:
        state_nxt = ball_pkg::hang;
    endcase
  end

  // rest timer and ghost timer
  always_ff @(posedge clk100Hz)
  begin
    if (rst_d)
    begin
      rest_cnt <= '0;
      ghost_cnt <= '0;
    end
    else
    begin
      rest_cnt <= (state == ball_pkg::rest) ? rest_cnt + 1'b1 : '0;
      if (state == ball_pkg::flight)
        ghost_cnt <= ghost_done ? ghost_cnt : ghost_cnt + 1'b1;
      else
        ghost_cnt <= '0;
    end
  end

endmodule

// ==== player_pos_delay.sv ====
module player_pos_delay (
  input  logic           clk100Hz,
  input  logic           rst_d,
  input  ball_pkg::pos_t pl1_pos,
  input  ball_pkg::pos_t pl2_pos,
  output ball_pkg::pos_t pl1_pos_d,
  output ball_pkg::pos_t pl2_pos_d
);

  ball_pkg::pos_t pl1_sr [ball_pkg::pos_delay_ticks];
  ball_pkg::pos_t pl2_sr [ball_pkg::pos_delay_ticks];

  // keeps positions in step with the collision strobes
  always_ff @(posedge clk100Hz)
  begin
    if (rst_d)
    begin
      for (int i = 0; i < ball_pkg::pos_delay_ticks; i++)
      begin
        pl1_sr[i] <= '0;
        pl2_sr[i] <= '0;
      end
    end
    else
    begin
      pl1_sr[0] <= pl1_pos;
      pl2_sr[0] <= pl2_pos;
      for (int i = 1; i < ball_pkg::pos_delay_ticks; i++)
      begin
        pl1_sr[i] <= pl1_sr[i-1];
        pl2_sr[i] <= pl2_sr[i-1];
      end
    end
  end

  assign pl1_pos_d = pl1_sr[ball_pkg::pos_delay_ticks-1];
  assign pl2_pos_d = pl2_sr[ball_pkg::pos_delay_ticks-1];

endmodule

// ==== ball_pkg.sv ====
package ball_pkg;

  // screen coordinate in pixels
  typedef logic [11:0] coord_t;

  // 13 integer bits, 7 fraction bits
  typedef logic signed [19:0] fix_t;

  // integer part of a fix_t value
  typedef logic signed [12:0] pix_t;

  typedef logic [7:0] rest_cnt_t;
  typedef logic [4:0] ghost_cnt_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
  } pos_t;

  typedef enum logic [1:0] {
    hang,
    bounce,
    flight,
    rest
  } ball_state_e;

  typedef enum logic [1:0] {
    col_none,
    col_pl1,
    col_pl2,
    col_wall
  } collision_e;

  localparam logic player1 = 1'b0;
  localparam logic player2 = 1'b1;

  // playfield limits
  localparam coord_t gnd_lvl = 12'd750;
  localparam coord_t ball_size = 12'd64;
  localparam coord_t wall_left = 12'd5;
  localparam coord_t wall_right = 12'd1018;

  // serve positions
  localparam coord_t start_x_pl1 = 12'd250;
  localparam coord_t start_x_pl2 = 12'd774;
  localparam coord_t start_y = 12'd555;

  // sprite centre offsets
  localparam coord_t pl_center_x = 12'd38;
  localparam coord_t pl_center_y = 12'd70;
  localparam coord_t ball_center = 12'd32;

  // 1/8 pixel per tick per tick
  localparam fix_t gravity = 20'sd16;
  localparam fix_t vel_y_min = -20'sd369;

  localparam rest_cnt_t rest_ticks = 8'd250;
  localparam ghost_cnt_t ghost_ticks = 5'd25;
  localparam int pos_delay_ticks = 3;

endpackage
